//--- sources.f
source/uart_line_pkg.sv
source/uart_ctrl_pkg.sv
source/serial_ctrl_if.sv
source/baud_timer.sv
source/uart_ctrl.sv
source/tx_shifter.sv
source/rx_shifter.sv
source/rx_fifo.sv
source/quick_rs232.sv
dv/tb_quick_rs232.sv

//--- Bender.yml
package:
  name: quick_rs232

sources:
  - source/uart_line_pkg.sv
  - source/uart_ctrl_pkg.sv
  - source/serial_ctrl_if.sv
  - source/baud_timer.sv
  - source/uart_ctrl.sv
  - source/tx_shifter.sv
  - source/rx_shifter.sv
  - source/rx_fifo.sv
  - source/quick_rs232.sv
  - target: test
    files:
      - dv/tb_quick_rs232.sv

//--- dv/tb_quick_rs232.sv
`timescale 1ns/1ps
`default_nettype none

module tb_quick_rs232;
    import uart_line_pkg::*;

    localparam int          BIT_CLKS       = int'(CLKS_PER_BIT);
    localparam int          FRAME_CLKS     = 11 * BIT_CLKS;
    localparam int          NUM_TX         = 24;
    localparam int          NUM_RX         = 24;
    localparam int          STALL_AFTER    = 2;     // Frames received before reads stop
    localparam int          TIMEOUT_CYCLES = (NUM_TX + NUM_RX) * 12 * BIT_CLKS + 2000;
    localparam logic [31:0] SEED           = 32'hbbbf_7d1e;

    logic  clk = 1'b0;
    logic  rst;
    logic  rx;
    logic  tx;
    logic  rts;
    logic  cts;
    logic  rx_read;
    byte_t rx_data;
    logic  rx_valid;
    logic  rx_err;
    byte_t tx_data;
    logic  tx_data_ready;
    logic  tx_data_copied;
    logic  tx_busy;

    // Reference model
    byte_t tx_exp[$];                   // Accepted bytes not yet seen on the line
    byte_t rx_exp[$];                   // Good bytes sent by the host in order
    int    corrupt_count     = 0;
    int    err_count         = 0;
    int    tx_frames_checked = 0;
    int    host_frames       = 0;
    int    cycle_count       = 0;
    int    busy_cycles       = 0;
    logic  host_done         = 1'b0;
    logic  stall_active      = 1'b0;
    logic  stall_cts_seen    = 1'b0;

    // Values seen at the previous rising edge
    logic  prev_live  = 1'b0;
    logic  prev_start = 1'b0;
    logic  prev_rts   = 1'b0;
    logic  prev_valid = 1'b0;

    quick_rs232 dut0 (
        .clk            (clk),
        .rst            (rst),
        .rx             (rx),
        .tx             (tx),
        .rts            (rts),
        .cts            (cts),
        .rx_read        (rx_read),
        .rx_data        (rx_data),
        .rx_valid       (rx_valid),
        .rx_err         (rx_err),
        .tx_data        (tx_data),
        .tx_data_ready  (tx_data_ready),
        .tx_data_copied (tx_data_copied),
        .tx_busy        (tx_busy)
    );

    always #4 clk = ~clk;

    task automatic abort_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            abort_run();
        end
    endtask

    //////////////////////////////////////////////////
    // Host side of the receive line
    //////////////////////////////////////////////////

    task automatic send_rx_frame(input byte_t data, input logic corrupt);
        rx = 1'b0;                      // Start bit
        repeat (BIT_CLKS) @(negedge clk);
        for (int i = 0; i < DATA_BITS; i++)
        begin
            rx = data[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
        rx = (^data) ^ corrupt;         // Even parity inverted on a bad frame
        repeat (BIT_CLKS) @(negedge clk);
        rx = 1'b1;                      // Stop bit
        repeat (BIT_CLKS) @(negedge clk);
    endtask

    task automatic drive_rx_frames();
        byte_t data;
        logic  corrupt;
        for (int n = 0; n < NUM_RX; n++)
        begin
            data    = byte_t'($urandom);
            corrupt = ($urandom_range(7) == 0);
            repeat ($urandom_range(40)) @(negedge clk);
            @(negedge clk);
            while (!cts)
                @(negedge clk);         // Wait for clear to send
            if (corrupt)
                corrupt_count++;
            else
                rx_exp.push_back(data);
            send_rx_frame(data, corrupt);
            host_frames++;
        end
        host_done = 1'b1;
    endtask

    task automatic offer_tx_bytes();
        for (int n = 0; n < NUM_TX; n++)
        begin
            repeat ($urandom_range(300)) @(negedge clk);
            tx_data       = byte_t'($urandom);
            tx_data_ready = 1'b1;
            @(negedge clk);
            while (!tx_data_copied)
                @(negedge clk);         // Held while the previous frame is sent
            tx_data_ready = 1'b0;
        end
    endtask

    // Samples each bit of one frame on tx at its centre
    task automatic decode_tx_frame();
        byte_t bits;
        logic  parity;
        logic  stop;
        @(posedge clk);
        while (tx !== 1'b0)
            @(posedge clk);
        repeat (int'(HALF_BIT_CLKS) - 1) @(posedge clk);
        check_equal("tx start bit", tx, 1'b0);
        for (int i = 0; i < DATA_BITS; i++)
        begin
            repeat (BIT_CLKS) @(posedge clk);
            bits[i] = tx;
        end
        repeat (BIT_CLKS) @(posedge clk);
        parity = tx;
        repeat (BIT_CLKS) @(posedge clk);
        stop = tx;
        if (tx_exp.size() == 0)
        begin
            $display("A frame appeared on tx without an accepted byte");
            abort_run();
        end
        else
        begin
            check_equal("tx data", bits, tx_exp.pop_front());
            check_equal("tx parity", ^{bits, parity}, 1'b0);
            check_equal("tx stop bit", stop, 1'b1);
            tx_frames_checked++;
        end
    endtask

    initial
    begin
        wait (!rst);
        forever
            decode_tx_frame();
    end

    initial
    begin
        wait (!rst);
        forever
        begin
            @(negedge clk);
            rts = 1'b1;
            repeat ($urandom_range(2500, 400)) @(negedge clk);
            rts = 1'b0;
            repeat ($urandom_range(20, 1)) @(negedge clk);
        end
    end

    initial
    begin
        wait (!rst);
        forever
        begin
            @(negedge clk);
            if (stall_active)
                rx_read = 1'b0;
            else
                rx_read = ($urandom_range(3) != 0);
        end
    end

    // Long read stall held until the buffer pushes back on cts
    initial
    begin
        wait (host_frames >= STALL_AFTER);
        stall_active = 1'b1;
        while (!stall_cts_seen && !host_done)
            @(negedge clk);
        repeat (3 * FRAME_CLKS) @(negedge clk);
        stall_active = 1'b0;
    end

    always @(posedge clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_count);
            abort_run();
        end
    end

    //////////////////////////////////////////////////
    // Cycle monitor sampled before each edge updates
    //////////////////////////////////////////////////

    always @(posedge clk)
    begin
        if (!rst)
        begin
            if (prev_live)
            begin
                check_equal("tx_data_copied", tx_data_copied, prev_start);
                if (!prev_rts)
                    check_equal("cts", cts, 1'b0);
                else if (!prev_valid)
                    check_equal("cts", cts, 1'b1);      // Empty buffer with rts high
                if (stall_active && prev_rts && !cts)
                    stall_cts_seen = 1'b1;
            end
            if (tx_busy)
                busy_cycles++;
            else
            begin
                check_equal("tx", tx, 1'b1);
                if (busy_cycles != 0)
                    check_equal("tx_busy cycles", busy_cycles, FRAME_CLKS);
                busy_cycles = 0;
            end
            if (tx_data_ready && !tx_busy)
                tx_exp.push_back(tx_data);
            if (rx_exp.size() == 0)
                check_equal("rx_valid", rx_valid, 1'b0);   // No good byte outstanding
            if (rx_read && rx_valid)
            begin
                if (rx_exp.size() == 0)
                begin
                    $display("A byte was read from the receive buffer but none was expected");
                    abort_run();
                end
                else
                    check_equal("rx_data", rx_data, rx_exp.pop_front());
            end
            if (rx_err)
            begin
                err_count++;
                if (err_count > corrupt_count)
                begin
                    $display("rx_err pulsed without a corrupted frame");
                    abort_run();
                end
            end
        end
        prev_live  = !rst;
        prev_start = tx_data_ready && !tx_busy;
        prev_rts   = rts;
        prev_valid = rx_valid;
    end

    initial
    begin
        void'($urandom(SEED));
        rst           = 1'b1;
        rx            = 1'b1;
        rts           = 1'b0;
        rx_read       = 1'b0;
        tx_data       = '0;
        tx_data_ready = 1'b0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        fork
            offer_tx_bytes();
            drive_rx_frames();
        join
        // Drain the last frames and the buffer
        while (tx_busy || tx_frames_checked < NUM_TX || rx_exp.size() != 0 || stall_active)
            @(negedge clk);
        check_equal("rx_err pulses", err_count, corrupt_count);
        check_equal("tx frames decoded", tx_frames_checked, NUM_TX);
        if (stall_cts_seen)
        begin
            $display("all tests passed");
            $finish;
        end
        else
        begin
            $display("cts never dropped while the receive buffer filled during the stall");
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- source/quick_rs232.sv
`timescale 1ns/1ps
`default_nettype none

module quick_rs232 (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx,
    output logic                 tx,
    input  logic                 rts,
    output logic                 cts,
    input  logic                 rx_read,
    output uart_line_pkg::byte_t rx_data,
    output logic                 rx_valid,
    output logic                 rx_err,
    input  uart_line_pkg::byte_t tx_data,
    input  logic                 tx_data_ready,
    output logic                 tx_data_copied,
    output logic                 tx_busy
);
    import uart_line_pkg::*;

    logic      tx_restart;
    logic      tx_tick;
    logic      rx_restart;
    logic      rx_half;
    logic      rx_tick;
    logic      rx_push;
    byte_t     rx_byte;
    fifo_cnt_t fifo_count;

    serial_ctrl_if ctl_if ();

    uart_ctrl ctrl0 (
        .clk            (clk),
        .rst            (rst),
        .ctl            (ctl_if.ctrl),
        .tx_data_ready  (tx_data_ready),
        .tx_data_copied (tx_data_copied),
        .tx_busy        (tx_busy),
        .tx_restart     (tx_restart),
        .tx_tick        (tx_tick),
        .rx_restart     (rx_restart),
        .rx_half        (rx_half),
        .rx_tick        (rx_tick),
        .rx_push        (rx_push),
        .rx_err         (rx_err),
        .rts            (rts),
        .fifo_count     (fifo_count),
        .cts            (cts)
    );

    baud_timer tx_timer (
        .clk     (clk),
        .rst     (rst),
        .restart (tx_restart),
        .half    (1'b0),           // Transmit bits start on a bit boundary
        .tick    (tx_tick)
    );

    baud_timer rx_timer (
        .clk     (clk),
        .rst     (rst),
        .restart (rx_restart),
        .half    (rx_half),
        .tick    (rx_tick)
    );

    tx_shifter tx_shift0 (
        .clk     (clk),
        .rst     (rst),
        .ctl     (ctl_if.tx),
        .tx_data (tx_data),
        .tx      (tx)
    );

    rx_shifter rx_shift0 (
        .clk     (clk),
        .rst     (rst),
        .ctl     (ctl_if.rx),
        .rx      (rx),
        .rx_byte (rx_byte)
    );

    rx_fifo rx_fifo0 (
        .clk       (clk),
        .rst       (rst),
        .push      (rx_push),
        .push_data (rx_byte),
        .pop       (rx_read),
        .pop_data  (rx_data),
        .valid     (rx_valid),
        .count     (fifo_count)
    );

endmodule

`default_nettype wire

//--- source/rx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module rx_fifo (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push,
    input  uart_line_pkg::byte_t     push_data,
    input  logic                     pop,
    output uart_line_pkg::byte_t     pop_data,
    output logic                     valid,
    output uart_line_pkg::fifo_cnt_t count
);
    import uart_line_pkg::*;

    byte_t                            mem [RX_FIFO_DEPTH];
    logic [$clog2(RX_FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(RX_FIFO_DEPTH)-1:0] rd_ptr;
    logic                             full;
    logic                             do_push;
    logic                             do_pop;

    assign full    = (count == fifo_cnt_t'(RX_FIFO_DEPTH));
    assign valid   = (count != '0);
    assign do_push = push && !full;
    assign do_pop  = pop && valid;     // Pop on empty is ignored

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign pop_data = mem[rd_ptr];     // Oldest byte shown first word fall through

    assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("push into full receive buffer");

endmodule

`default_nettype wire

//--- source/rx_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module rx_shifter (
    input  logic                 clk,
    input  logic                 rst,
    serial_ctrl_if.rx            ctl,
    input  logic                 rx,
    output uart_line_pkg::byte_t rx_byte
);
    import uart_line_pkg::*;

    logic [1:0] sync;      // Two-flop synchronizer
    byte_t      shreg;
    logic       parity;    // XOR of the data bits so far

    always_ff @(posedge clk)
    begin
        if (rst)
            sync <= 2'b11;
        else
            sync <= {sync[0], rx};
    end

    assign ctl.rx_line = sync[1];

    // Data arrives LSB first, so shift in from the top
    always_ff @(posedge clk)
    begin
        if (ctl.rx_clear)
        begin
            shreg  <= '0;
            parity <= 1'b0;
        end
        else if (ctl.rx_sample)
        begin
            shreg  <= {ctl.rx_line, shreg[DATA_BITS-1:1]};
            parity <= parity ^ ctl.rx_line;
        end
    end

    // Even parity holds when the parity bit equals the data XOR
    assign ctl.rx_parity_ok = (parity == ctl.rx_line);
    assign rx_byte          = shreg;

endmodule

`default_nettype wire

//--- source/tx_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module tx_shifter (
    input  logic                 clk,
    input  logic                 rst,
    serial_ctrl_if.tx            ctl,
    input  uart_line_pkg::byte_t tx_data,
    output logic                 tx
);
    import uart_line_pkg::*;
    import uart_ctrl_pkg::*;

    byte_t shreg;      // Bits still to send with the LSB first
    logic  parity;
    logic  data_bit;

    // A shift and the line register update on the same edge
    assign data_bit = ctl.tx_shift ? shreg[1] : shreg[0];

    always_ff @(posedge clk)
    begin
        if (ctl.tx_load)
        begin
            shreg  <= tx_data;
            parity <= ^tx_data;     // Even parity over the data bits
        end
        else if (ctl.tx_shift)
        begin
            shreg <= {1'b0, shreg[DATA_BITS-1:1]};
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            tx <= 1'b1;             // Line idles high
        else
        begin
            case (ctl.tx_sel)
                SEL_START:  tx <= 1'b0;
                SEL_DATA:   tx <= data_bit;
                SEL_PARITY: tx <= parity;
                default:    tx <= 1'b1;
            endcase
        end
    end

    // A new byte is loaded only while the line idles high
    assert property (@(posedge clk) disable iff (rst) ctl.tx_load |-> tx)
        else $error("tx_load while the line is not idle");

endmodule

`default_nettype wire

//--- source/uart_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module uart_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    serial_ctrl_if.ctrl              ctl,
    input  logic                     tx_data_ready,
    output logic                     tx_data_copied,
    output logic                     tx_busy,
    output logic                     tx_restart,
    input  logic                     tx_tick,
    output logic                     rx_restart,
    output logic                     rx_half,
    input  logic                     rx_tick,
    output logic                     rx_push,
    output logic                     rx_err,
    input  logic                     rts,
    input  uart_line_pkg::fifo_cnt_t fifo_count,
    output logic                     cts
);
    import uart_line_pkg::*;
    import uart_ctrl_pkg::*;

    //////////////////////////////////////////////////
    // Transmit frame
    //////////////////////////////////////////////////

    tx_state_e tx_state;
    tx_state_e tx_state_nxt;
    bit_idx_t  tx_idx;
    logic      tx_start;

    assign tx_start = (tx_state == TX_IDLE) && tx_data_ready;  // Only sampled while idle

    always_comb
    begin
        tx_state_nxt = tx_state;
        case (tx_state)
            TX_IDLE:
                if (tx_data_ready)
                    tx_state_nxt = TX_START;
            TX_START:
                if (tx_tick)
                    tx_state_nxt = TX_DATA;
            TX_DATA:
                if (tx_tick && tx_idx == bit_idx_t'(DATA_BITS - 1))
                    tx_state_nxt = TX_PARITY;
            TX_PARITY:
                if (tx_tick)
                    tx_state_nxt = TX_STOP;
            TX_STOP:
                if (tx_tick)
                    tx_state_nxt = TX_IDLE;
            default:
                tx_state_nxt = TX_IDLE;
        endcase
    end

    // The line is registered in the shifter, so select by the next state
    always_comb
    begin
        case (tx_state_nxt)
            TX_START:  ctl.tx_sel = SEL_START;
            TX_DATA:   ctl.tx_sel = SEL_DATA;
            TX_PARITY: ctl.tx_sel = SEL_PARITY;
            default:   ctl.tx_sel = SEL_IDLE;   // Idle and stop bit
        endcase
    end

    assign ctl.tx_load  = tx_start;
    assign ctl.tx_shift = (tx_state == TX_DATA) && tx_tick
                          && (tx_idx != bit_idx_t'(DATA_BITS - 1));
    assign tx_restart   = tx_start;
    assign tx_busy      = (tx_state != TX_IDLE);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tx_state       <= TX_IDLE;
            tx_idx         <= '0;
            tx_data_copied <= 1'b0;
        end
        else
        begin
            tx_state       <= tx_state_nxt;
            tx_data_copied <= tx_start;
            if (tx_start)
                tx_idx <= '0;
            else if (ctl.tx_shift)
                tx_idx <= tx_idx + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // Receive frame
    //////////////////////////////////////////////////

    rx_state_e rx_state;
    bit_idx_t  rx_idx;
    logic      rx_line_q;   // Line one cycle back for edge detection
    logic      rx_par_ok;   // Held from the parity sample to the stop sample
    logic      rx_fall;

    assign rx_fall       = rx_line_q && !ctl.rx_line;
    assign rx_restart    = (rx_state == RX_IDLE) && rx_fall;
    assign rx_half       = (rx_state == RX_IDLE);   // First tick lands mid start bit
    assign ctl.rx_clear  = rx_restart;
    assign ctl.rx_sample = (rx_state == RX_DATA) && rx_tick;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rx_state  <= RX_IDLE;
            rx_idx    <= '0;
            rx_line_q <= 1'b1;
            rx_par_ok <= 1'b0;
            rx_push   <= 1'b0;
            rx_err    <= 1'b0;
        end
        else
        begin
            rx_line_q <= ctl.rx_line;
            rx_push   <= 1'b0;
            rx_err    <= 1'b0;
            case (rx_state)
                RX_IDLE:
                    if (rx_fall)
                        rx_state <= RX_START;
                RX_START:
                    if (rx_tick)
                    begin
                        if (ctl.rx_line)
                            rx_state <= RX_IDLE;    // Glitch rather than a start bit
                        else
                            rx_state <= RX_DATA;
                        rx_idx <= '0;
                    end
                RX_DATA:
                    if (rx_tick)
                    begin
                        rx_idx <= rx_idx + 1'b1;
                        if (rx_idx == bit_idx_t'(DATA_BITS - 1))
                            rx_state <= RX_PARITY;
                    end
                RX_PARITY:
                    if (rx_tick)
                    begin
                        rx_par_ok <= ctl.rx_parity_ok;
                        rx_state  <= RX_STOP;
                    end
                RX_STOP:
                    if (rx_tick)
                    begin
                        if (rx_par_ok && ctl.rx_line)
                            rx_push <= 1'b1;
                        else
                            rx_err <= 1'b1;     // Bad parity or framing
                        rx_state <= RX_IDLE;
                    end
                default:
                    rx_state <= RX_IDLE;
            endcase
        end
    end

    // cts follows rts unless the buffer is nearly full
    always_ff @(posedge clk)
    begin
        if (rst)
            cts <= 1'b0;
        else
            cts <= rts && (fifo_count < RX_CTS_LIMIT);
    end

    assert property (@(posedge clk) disable iff (rst) tx_data_copied |=> !tx_data_copied)
        else $error("tx_data_copied high for two cycles");

    // A half-bit restart must not tick on the very next cycle
    assert property (@(posedge clk) disable iff (rst) rx_restart |=> !rx_tick)
        else $error("rx_tick right after a restart");

endmodule

`default_nettype wire

//--- source/baud_timer.sv
`timescale 1ns/1ps
`default_nettype none

module baud_timer (
    input  logic clk,
    input  logic rst,
    input  logic restart,
    input  logic half,
    output logic tick
);
    import uart_line_pkg::*;

    clk_cnt_t cnt;     // Cycles left until the next tick

    // Down-counter that reloads the full period after every tick
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt <= CLKS_PER_BIT - clk_cnt_t'(1);
        end
        else if (restart)
        begin
            if (half)
                cnt <= HALF_BIT_CLKS - clk_cnt_t'(1);  // First tick at a bit centre
            else
                cnt <= CLKS_PER_BIT - clk_cnt_t'(1);
        end
        else if (cnt == '0)
        begin
            cnt <= CLKS_PER_BIT - clk_cnt_t'(1);
        end
        else
        begin
            cnt <= cnt - clk_cnt_t'(1);
        end
    end

    assign tick = (cnt == '0);

endmodule

`default_nettype wire

//--- source/serial_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface serial_ctrl_if;
    import uart_ctrl_pkg::*;

    // Transmit side
    logic        tx_load;       // Capture the byte and its parity
    logic        tx_shift;      // Advance to the next data bit
    tx_bit_sel_e tx_sel;        // Line source for the next cycle

    // Receive side
    logic        rx_clear;      // Start of a new frame
    logic        rx_sample;     // Data bit centre
    logic        rx_line;       // Synchronized rx
    logic        rx_parity_ok;  // Running parity matches the line

    modport ctrl (
        output tx_load,
        output tx_shift,
        output tx_sel,
        output rx_clear,
        output rx_sample,
        input  rx_line,
        input  rx_parity_ok
    );

    modport tx (
        input  tx_load,
        input  tx_shift,
        input  tx_sel
    );

    modport rx (
        input  rx_clear,
        input  rx_sample,
        output rx_line,
        output rx_parity_ok
    );

endinterface

`default_nettype wire

//--- source/uart_ctrl_pkg.sv
`default_nettype none

package uart_ctrl_pkg;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_PARITY,
        TX_STOP
    } tx_state_e;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_PARITY,
        RX_STOP
    } rx_state_e;

    // Source of the next transmit line level
    typedef enum logic [1:0] {
        SEL_IDLE,       // Also used for the stop bit
        SEL_START,
        SEL_DATA,
        SEL_PARITY
    } tx_bit_sel_e;

    typedef logic [2:0] bit_idx_t;

endpackage

`default_nettype wire

//--- source/uart_line_pkg.sv
`default_nettype none

package uart_line_pkg;

    // Line timing
    localparam logic [31:0] CLK_FREQ_HZ = 32'd50_000_000;
    localparam logic [31:0] BAUD_RATE   = 32'd115_200;

    typedef logic [8:0] clk_cnt_t;     // Holds one bit period

    localparam clk_cnt_t CLKS_PER_BIT  = clk_cnt_t'(CLK_FREQ_HZ / BAUD_RATE);  // 434
    localparam clk_cnt_t HALF_BIT_CLKS = clk_cnt_t'(CLKS_PER_BIT / 2);         // 217

    // 8E1 frame format
    localparam int unsigned DATA_BITS = 8;

    typedef logic [DATA_BITS-1:0] byte_t;

    // Receive buffer
    localparam int unsigned RX_FIFO_DEPTH = 16;

    typedef logic [4:0] fifo_cnt_t;    // 0 to 16 entries

    // Two frames of headroom before the buffer fills
    localparam fifo_cnt_t RX_CTS_LIMIT = fifo_cnt_t'(14);

endpackage

`default_nettype wire
